// File: hdl/cpri_hdr_pkg.sv
// CPRI uplink header definitions
// Field types, the packed header view and the uplink filter constants
`default_nettype none

package cpri_hdr_pkg;

    typedef logic [63:0] word_t;
    typedef logic [3:0]  pkg_type_t;
    typedef logic [6:0]  slot_idx_t;
    typedef logic [3:0]  symb_idx_t;
    typedef logic [7:0]  prb_idx_t;

    // Header word, MSB first; reserved and antenna bits are not used
    typedef struct packed {
        logic [23:0] rsvd_hi;
        pkg_type_t   pkg_type;
        prb_idx_t    prb0;
        prb_idx_t    prb1;
        logic        rsvd_mid;
        slot_idx_t   slot;
        symb_idx_t   symb;
        logic [7:0]  rsvd_lo;
    } cpri_hdr_t;

    // Uplink shared channel packets
    localparam pkg_type_t PUSCH_PKG_TYPE = 4'd8;

    // Uplink slots are 4, 9, 14 ... 79
    localparam slot_idx_t UL_SLOT_PERIOD = 7'd5;
    localparam slot_idx_t UL_SLOT_PHASE  = 7'd4;
    localparam slot_idx_t UL_SLOT_COUNT  = 7'd80;

    // PRB range of the packet that opens a symbol block
    localparam prb_idx_t SOP_PRB0 = 8'd0;
    localparam prb_idx_t SOP_PRB1 = 8'd4;

endpackage

`default_nettype wire

// File: hdl/cpri_buf_pkg.sv
// Receive buffer definitions
// Block, chip and bank sizes plus the structs between filter, writer and banks
`default_nettype none

package cpri_buf_pkg;

    //--------------------------------------------------
    // Sizes
    //--------------------------------------------------
    // One symbol block is 33 chips of 96 words
    localparam int BLOCK_WORDS = 3168;
    localparam int CHIP_WORDS  = 96;

    // Block words whose upper halves carry the FFT AGC pair
    localparam int AGC_EVEN_ADDR = 4;
    localparam int AGC_ODD_ADDR  = 1636;

    localparam int NUM_BANKS = 2;

    //--------------------------------------------------
    // Types
    //--------------------------------------------------
    typedef logic [11:0] blk_addr_t;
    typedef logic [6:0]  chip_addr_t;
    typedef logic [0:0]  bank_sel_t;

    // Odd half in 63:32, even half in 31:0
    typedef logic [63:0] agc_t;

    typedef struct packed {
        logic                en;
        bank_sel_t           bank;
        blk_addr_t           addr;
        cpri_hdr_pkg::word_t data;
    } wr_req_t;

    typedef struct packed {
        logic                valid;
        logic                start;
        cpri_hdr_pkg::word_t data;
    } pay_t;

endpackage

`default_nettype wire

// File: hdl/cpri_hdr_filter.sv
// CPRI header filter
// Captures the header of each valid run, keeps uplink shared channel
// packets and forwards their payload with a block start flag
`timescale 1ns/10ps
`default_nettype none

module cpri_hdr_filter (
    input  wire                 i_clk,
    input  wire                 cpri_reset,
    input  cpri_hdr_pkg::word_t i_rx_data,
    input  wire                 i_rvalid,
    input  wire                 i_enable,
    output cpri_buf_pkg::pay_t  o_pay
);

    logic                    rvalid_d;
    logic                    rvalid_d2;
    logic                    first_word;
    logic                    first_pay;
    cpri_hdr_pkg::cpri_hdr_t hdr;
    logic                    pusch_pkt;
    logic                    slot_ok;
    logic                    sop_hdr;
    logic                    keep;
    logic                    pay_vld;
    logic                    pay_start;
    cpri_hdr_pkg::word_t     pay_data;

    //--------------------------------------------------
    // Run tracking and header capture
    //--------------------------------------------------
    assign first_word = i_rvalid & ~rvalid_d;
    // Second word of a run
    assign first_pay  = i_rvalid & rvalid_d & ~rvalid_d2;

    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            rvalid_d  <= 1'b0;
            rvalid_d2 <= 1'b0;
        end else begin
            rvalid_d  <= i_rvalid;
            rvalid_d2 <= rvalid_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (first_word) begin
            hdr <= cpri_hdr_pkg::cpri_hdr_t'(i_rx_data);
        end
    end

    //--------------------------------------------------
    // Keep/drop decision
    //--------------------------------------------------
    assign pusch_pkt = (hdr.pkg_type == cpri_hdr_pkg::PUSCH_PKG_TYPE);
    assign slot_ok   = ((hdr.slot % cpri_hdr_pkg::UL_SLOT_PERIOD) == cpri_hdr_pkg::UL_SLOT_PHASE)
                    && (hdr.slot < cpri_hdr_pkg::UL_SLOT_COUNT);
    assign keep      = pusch_pkt & slot_ok;
    assign sop_hdr   = (hdr.symb == '0) && (hdr.prb0 == cpri_hdr_pkg::SOP_PRB0)
                    && (hdr.prb1 == cpri_hdr_pkg::SOP_PRB1);

    // Payload leaves one cycle behind the input
    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            pay_vld   <= 1'b0;
            pay_start <= 1'b0;
        end else begin
            pay_vld   <= i_rvalid & rvalid_d & keep;
            pay_start <= first_pay & keep & sop_hdr & i_enable;
        end
    end

    always_ff @(posedge i_clk) begin
        pay_data <= i_rx_data;
    end

    assign o_pay = '{valid: pay_vld, start: pay_start, data: pay_data};

    // Payload of a run only starts two cycles after its header word
    a_pay_after_hdr: assert property (@(posedge i_clk) disable iff (cpri_reset)
        $rose(pay_vld) |-> $past(first_word, 2));

endmodule

`default_nettype wire

// File: hdl/cpri_blk_writer.sv
// Symbol block writer
// Claims a bank on the block start word, addresses 3168 payload words
// into it and captures the FFT AGC pair on the way
`timescale 1ns/10ps
`default_nettype none

module cpri_blk_writer (
    input  wire                    i_clk,
    input  wire                    cpri_reset,
    input  cpri_buf_pkg::pay_t     i_pay,
    input  wire                    i_wr_free,
    input  cpri_buf_pkg::bank_sel_t i_wr_bank,
    output cpri_buf_pkg::wr_req_t  o_wr,
    output logic                   o_blk_done,
    output cpri_buf_pkg::agc_t     o_agc
);

    localparam cpri_buf_pkg::blk_addr_t LAST_ADDR =
        cpri_buf_pkg::blk_addr_t'(cpri_buf_pkg::BLOCK_WORDS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITING,
        ST_DROPPING
    } wr_state_t;

    wr_state_t               state;
    cpri_buf_pkg::blk_addr_t wr_cnt;
    logic                    wr_en;
    logic                    wr_last;
    cpri_buf_pkg::bank_sel_t wr_bank;
    cpri_buf_pkg::blk_addr_t wr_addr;
    cpri_hdr_pkg::word_t     wr_data;
    logic [31:0]             agc_even;
    logic [31:0]             agc_odd;

    //--------------------------------------------------
    // Block FSM
    //--------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            state      <= ST_IDLE;
            wr_cnt     <= '0;
            wr_en      <= 1'b0;
            wr_last    <= 1'b0;
            o_blk_done <= 1'b0;
        end else begin
            wr_en      <= 1'b0;
            wr_last    <= 1'b0;
            o_blk_done <= wr_last;
            case (state)
                ST_IDLE, ST_DROPPING: begin
                    // Bank state only matters at a block start
                    if (i_pay.valid && i_pay.start) begin
                        if (i_wr_free) begin
                            wr_en  <= 1'b1;
                            wr_cnt <= cpri_buf_pkg::blk_addr_t'(1);
                            state  <= ST_WRITING;
                        end else begin
                            state <= ST_DROPPING;
                        end
                    end
                end
                ST_WRITING: begin
                    if (i_pay.valid) begin
                        wr_en  <= 1'b1;
                        wr_cnt <= wr_cnt + 1'b1;
                        if (wr_cnt == LAST_ADDR) begin
                            wr_last <= 1'b1;
                            wr_cnt  <= '0;
                            state   <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Start word always lands on address 0
    always_ff @(posedge i_clk) begin
        wr_bank <= i_wr_bank;
        wr_addr <= (state == ST_WRITING) ? wr_cnt : '0;
        wr_data <= i_pay.data;
    end

    assign o_wr = '{en: wr_en, bank: wr_bank, addr: wr_addr, data: wr_data};

    //--------------------------------------------------
    // FFT AGC capture
    //--------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (wr_en && wr_addr == cpri_buf_pkg::blk_addr_t'(cpri_buf_pkg::AGC_EVEN_ADDR)) begin
            agc_even <= wr_data[63:32];
        end
        if (wr_en && wr_addr == cpri_buf_pkg::blk_addr_t'(cpri_buf_pkg::AGC_ODD_ADDR)) begin
            agc_odd <= wr_data[63:32];
        end
    end

    assign o_agc = {agc_odd, agc_even};

    a_addr_in_block: assert property (@(posedge i_clk) disable iff (cpri_reset)
        wr_en |-> wr_addr <= LAST_ADDR);

endmodule

`default_nettype wire

// File: hdl/cpri_bank_ram.sv
// Two-bank block memory
// One bank fills while the other drains; full flags and the AGC pair
// are kept per bank
`timescale 1ns/10ps
`default_nettype none

module cpri_bank_ram (
    input  wire                     i_clk,
    input  wire                     cpri_reset,
    input  cpri_buf_pkg::wr_req_t   i_wr,
    input  wire                     i_blk_done,
    input  cpri_buf_pkg::agc_t      i_agc,
    input  cpri_buf_pkg::blk_addr_t i_rd_addr,
    input  wire                     i_rd_done,
    output logic                    o_wr_free,
    output cpri_buf_pkg::bank_sel_t o_wr_bank,
    output logic                    o_rd_ready,
    output cpri_hdr_pkg::word_t     o_rd_data,
    output cpri_buf_pkg::agc_t      o_rd_agc
);

    cpri_hdr_pkg::word_t mem [cpri_buf_pkg::NUM_BANKS][cpri_buf_pkg::BLOCK_WORDS];
    cpri_buf_pkg::agc_t  agc_mem [cpri_buf_pkg::NUM_BANKS];

    logic [cpri_buf_pkg::NUM_BANKS-1:0] full;
    cpri_buf_pkg::bank_sel_t            wr_bank;
    cpri_buf_pkg::bank_sel_t            rd_bank;

    //--------------------------------------------------
    // Bank pointers and full flags
    //--------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            full    <= '0;
            wr_bank <= '0;
            rd_bank <= '0;
        end else begin
            if (i_blk_done) begin
                full[wr_bank] <= 1'b1;
                wr_bank       <= wr_bank + 1'b1;
            end
            if (i_rd_done) begin
                full[rd_bank] <= 1'b0;
                rd_bank       <= rd_bank + 1'b1;
            end
        end
    end

    //--------------------------------------------------
    // Storage
    //--------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_wr.en) begin
            mem[i_wr.bank][i_wr.addr] <= i_wr.data;
        end
        o_rd_data <= mem[rd_bank][i_rd_addr];
    end

    always_ff @(posedge i_clk) begin
        if (i_blk_done) begin
            agc_mem[wr_bank] <= i_agc;
        end
    end

    // Write bank full means both banks hold a block
    assign o_wr_free  = ~full[wr_bank];
    assign o_wr_bank  = wr_bank;
    assign o_rd_ready = full[rd_bank];
    assign o_rd_agc   = agc_mem[rd_bank];

    // Writer only claims a free bank, so completion never lands on a full one
    a_done_to_free: assert property (@(posedge i_clk) disable iff (cpri_reset)
        i_blk_done |-> !full[wr_bank]);

endmodule

`default_nettype wire

// File: hdl/cpri_chip_reader.sv
// Chip reader
// Drains a full bank as 33 chips of 96 words with chip address,
// chip last and end-of-symbol tags aligned to the RAM data
`timescale 1ns/10ps
`default_nettype none

module cpri_chip_reader (
    input  wire                      i_clk,
    input  wire                      cpri_reset,
    input  wire                      i_rd_en,
    input  wire                      i_rready,
    input  wire                      i_rd_ready,
    input  cpri_hdr_pkg::word_t      i_rd_data,
    input  cpri_buf_pkg::agc_t       i_rd_agc,
    output cpri_buf_pkg::blk_addr_t  o_rd_addr,
    output logic                     o_rd_done,
    output cpri_hdr_pkg::word_t      o_tx_data,
    output cpri_buf_pkg::chip_addr_t o_tx_addr,
    output logic                     o_tx_last,
    output logic                     o_symb_eop,
    output logic                     o_tvalid,
    output cpri_buf_pkg::agc_t       o_fft_agc
);

    localparam cpri_buf_pkg::blk_addr_t BLK_LAST =
        cpri_buf_pkg::blk_addr_t'(cpri_buf_pkg::BLOCK_WORDS - 1);
    localparam cpri_buf_pkg::chip_addr_t CHIP_LAST =
        cpri_buf_pkg::chip_addr_t'(cpri_buf_pkg::CHIP_WORDS - 1);

    typedef struct packed {
        logic                     valid;
        cpri_buf_pkg::chip_addr_t addr;
        logic                     last;
        logic                     eop;
    } tag_t;

    logic                     fetch;
    cpri_buf_pkg::blk_addr_t  rd_addr;
    cpri_buf_pkg::chip_addr_t chip_cnt;
    tag_t                     tag_s1;
    tag_t                     tag_s2;
    cpri_buf_pkg::agc_t       agc_s1;

    //--------------------------------------------------
    // Fetch addressing
    //--------------------------------------------------
    assign fetch     = i_rd_ready & i_rd_en & i_rready;
    assign o_rd_addr = rd_addr;
    assign o_rd_done = fetch && (rd_addr == BLK_LAST);

    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            rd_addr  <= '0;
            chip_cnt <= '0;
        end else if (fetch) begin
            rd_addr  <= (rd_addr == BLK_LAST) ? '0 : rd_addr + 1'b1;
            chip_cnt <= (chip_cnt == CHIP_LAST) ? '0 : chip_cnt + 1'b1;
        end
    end

    //--------------------------------------------------
    // Tag pipeline matched to the RAM latency
    //--------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (cpri_reset) begin
            tag_s1 <= '0;
            tag_s2 <= '0;
        end else begin
            tag_s1 <= '{valid: fetch,
                        addr:  chip_cnt,
                        last:  fetch && (chip_cnt == CHIP_LAST),
                        eop:   o_rd_done};
            tag_s2 <= tag_s1;
        end
    end

    // AGC travels with the fetched word since the bank switches after the last one
    always_ff @(posedge i_clk) begin
        agc_s1    <= i_rd_agc;
        o_fft_agc <= agc_s1;
        o_tx_data <= i_rd_data;
    end

    assign o_tvalid   = tag_s2.valid;
    assign o_tx_addr  = tag_s2.addr;
    assign o_tx_last  = tag_s2.last;
    assign o_symb_eop = tag_s2.eop;

    // Chip counter stays in step with the block address
    a_chip_in_step: assert property (@(posedge i_clk) disable iff (cpri_reset)
        fetch |-> chip_cnt == cpri_buf_pkg::chip_addr_t'(rd_addr % cpri_buf_pkg::CHIP_WORDS));

endmodule

`default_nettype wire

// File: hdl/cpri_rx_top.sv
// CPRI uplink receive buffer
// Filter, block writer, two-bank memory and chip reader on one clock
`timescale 1ns/10ps
`default_nettype none

module cpri_rx_top (
    input  wire                      i_clk,
    input  wire                      cpri_reset,
    input  cpri_hdr_pkg::word_t      i_rx_data,
    input  wire                      i_rvalid,
    input  wire                      i_enable,
    input  wire                      i_rd_en,
    input  wire                      i_rready,
    output cpri_hdr_pkg::word_t      o_tx_data,
    output cpri_buf_pkg::chip_addr_t o_tx_addr,
    output logic                     o_tx_last,
    output logic                     o_symb_eop,
    output logic                     o_tvalid,
    output cpri_buf_pkg::agc_t       o_fft_agc,
    output logic                     o_tready
);

    cpri_buf_pkg::pay_t      pay;
    cpri_buf_pkg::wr_req_t   wr;
    logic                    blk_done;
    cpri_buf_pkg::agc_t      wr_agc;
    logic                    wr_free;
    cpri_buf_pkg::bank_sel_t wr_bank;
    logic                    rd_ready;
    cpri_hdr_pkg::word_t     rd_data;
    cpri_buf_pkg::agc_t      rd_agc;
    cpri_buf_pkg::blk_addr_t rd_addr;
    logic                    rd_done;

    //--------------------------------------------------
    // Write side
    //--------------------------------------------------
    cpri_hdr_filter u_filter (
        .i_clk      (i_clk),
        .cpri_reset (cpri_reset),
        .i_rx_data  (i_rx_data),
        .i_rvalid   (i_rvalid),
        .i_enable   (i_enable),
        .o_pay      (pay)
    );

    cpri_blk_writer u_writer (
        .i_clk      (i_clk),
        .cpri_reset (cpri_reset),
        .i_pay      (pay),
        .i_wr_free  (wr_free),
        .i_wr_bank  (wr_bank),
        .o_wr       (wr),
        .o_blk_done (blk_done),
        .o_agc      (wr_agc)
    );

    cpri_bank_ram u_banks (
        .i_clk      (i_clk),
        .cpri_reset (cpri_reset),
        .i_wr       (wr),
        .i_blk_done (blk_done),
        .i_agc      (wr_agc),
        .i_rd_addr  (rd_addr),
        .i_rd_done  (rd_done),
        .o_wr_free  (wr_free),
        .o_wr_bank  (wr_bank),
        .o_rd_ready (rd_ready),
        .o_rd_data  (rd_data),
        .o_rd_agc   (rd_agc)
    );

    //--------------------------------------------------
    // Read side
    //--------------------------------------------------
    cpri_chip_reader u_reader (
        .i_clk      (i_clk),
        .cpri_reset (cpri_reset),
        .i_rd_en    (i_rd_en),
        .i_rready   (i_rready),
        .i_rd_ready (rd_ready),
        .i_rd_data  (rd_data),
        .i_rd_agc   (rd_agc),
        .o_rd_addr  (rd_addr),
        .o_rd_done  (rd_done),
        .o_tx_data  (o_tx_data),
        .o_tx_addr  (o_tx_addr),
        .o_tx_last  (o_tx_last),
        .o_symb_eop (o_symb_eop),
        .o_tvalid   (o_tvalid),
        .o_fft_agc  (o_fft_agc)
    );

    // Low only while both banks hold a block
    assign o_tready = wr_free;

endmodule

`default_nettype wire

// File: tb/cpri_rx_tb.sv
// Testbench for the CPRI uplink receive buffer
// Sends header/payload packets, models the filter and the two banks,
// and compares every read-out word and tag against the model
`timescale 1ns/10ps
`default_nettype none

module cpri_rx_tb;

    // 22 kept packets of 144 payload words fill one block
    localparam int PKT_PAY   = 144;
    localparam int BLK_PKTS  = 22;
    localparam int BLKS_SENT = 8;
    localparam int DROP_PKTS = 6;
    localparam int DROP_PAY  = 48;
    localparam int SENT_WORDS = BLKS_SENT * BLK_PKTS * (PKT_PAY + 1)
                              + DROP_PKTS * (DROP_PAY + 1);
    localparam int WATCHDOG_CYCLES = SENT_WORDS * 4 + 2000;

    typedef struct packed {
        cpri_hdr_pkg::word_t      data;
        cpri_buf_pkg::chip_addr_t addr;
        logic                     last;
        logic                     eop;
        cpri_buf_pkg::agc_t       agc;
    } beat_t;

    logic                     i_clk;
    logic                     cpri_reset;
    cpri_hdr_pkg::word_t      i_rx_data;
    logic                     i_rvalid;
    logic                     i_enable;
    logic                     i_rd_en;
    logic                     i_rready;
    cpri_hdr_pkg::word_t      o_tx_data;
    cpri_buf_pkg::chip_addr_t o_tx_addr;
    logic                     o_tx_last;
    logic                     o_symb_eop;
    logic                     o_tvalid;
    cpri_buf_pkg::agc_t       o_fft_agc;
    logic                     o_tready;

    integer              seed;
    int                  value_errs;
    int                  stream_errs;
    beat_t               exp_q[$];
    beat_t               exp_beat;
    // Model of the block writer: 0 idle, 1 writing, 2 dropping
    int                  mdl_state;
    int                  blk_cnt;
    int                  pending;
    cpri_hdr_pkg::word_t blk_buf [cpri_buf_pkg::BLOCK_WORDS];

    cpri_rx_top uut (
        .i_clk      (i_clk),
        .cpri_reset (cpri_reset),
        .i_rx_data  (i_rx_data),
        .i_rvalid   (i_rvalid),
        .i_enable   (i_enable),
        .i_rd_en    (i_rd_en),
        .i_rready   (i_rready),
        .o_tx_data  (o_tx_data),
        .o_tx_addr  (o_tx_addr),
        .o_tx_last  (o_tx_last),
        .o_symb_eop (o_symb_eop),
        .o_tvalid   (o_tvalid),
        .o_fft_agc  (o_fft_agc),
        .o_tready   (o_tready)
    );

    always #50 i_clk = ~i_clk;

    //--------------------------------------------------
    // Reference model
    //--------------------------------------------------
    // Bit 1 kept, bit 0 opens a block
    function automatic logic [1:0] classify_hdr(input cpri_hdr_pkg::word_t w);
        logic kept;
        logic opens;
        kept  = (w[39:36] == cpri_hdr_pkg::PUSCH_PKG_TYPE)
             && ((w[18:12] % cpri_hdr_pkg::UL_SLOT_PERIOD) == cpri_hdr_pkg::UL_SLOT_PHASE)
             && (w[18:12] < cpri_hdr_pkg::UL_SLOT_COUNT);
        opens = (w[11:8] == 4'd0) && (w[35:28] == cpri_hdr_pkg::SOP_PRB0)
             && (w[27:20] == cpri_hdr_pkg::SOP_PRB1);
        return {kept, opens};
    endfunction

    function automatic cpri_buf_pkg::agc_t agc_pair(input cpri_hdr_pkg::word_t even_w,
                                                    input cpri_hdr_pkg::word_t odd_w);
        return {odd_w[63:32], even_w[63:32]};
    endfunction

    function automatic beat_t expected_beat(input cpri_hdr_pkg::word_t data, input int k,
                                            input cpri_buf_pkg::agc_t agc);
        beat_t b;
        b.data = data;
        b.addr = cpri_buf_pkg::chip_addr_t'(k % cpri_buf_pkg::CHIP_WORDS);
        b.last = (k % cpri_buf_pkg::CHIP_WORDS) == cpri_buf_pkg::CHIP_WORDS - 1;
        b.eop  = (k == cpri_buf_pkg::BLOCK_WORDS - 1);
        b.agc  = agc;
        return b;
    endfunction

    task automatic push_block;
        cpri_buf_pkg::agc_t agc;
        int                 k;
        agc = agc_pair(blk_buf[cpri_buf_pkg::AGC_EVEN_ADDR], blk_buf[cpri_buf_pkg::AGC_ODD_ADDR]);
        for (k = 0; k < cpri_buf_pkg::BLOCK_WORDS; k++) begin
            exp_q.push_back(expected_beat(blk_buf[k], k, agc));
        end
    endtask

    task automatic model_payload(input logic [1:0] cls, input logic first,
                                 input cpri_hdr_pkg::word_t pay);
        if (cls[1]) begin
            if (mdl_state != 1 && first && cls[0] && i_enable) begin
                mdl_state = (pending < cpri_buf_pkg::NUM_BANKS) ? 1 : 2;
                blk_cnt   = 0;
            end
            if (mdl_state == 1) begin
                blk_buf[blk_cnt] = pay;
                blk_cnt++;
                if (blk_cnt == cpri_buf_pkg::BLOCK_WORDS) begin
                    push_block();
                    pending++;
                    mdl_state = 0;
                end
            end
        end
    endtask

    //--------------------------------------------------
    // Stimulus
    //--------------------------------------------------
    function automatic cpri_hdr_pkg::word_t make_hdr(input int ptype, input int slot,
                                                     input int prb0, input int prb1,
                                                     input int symb);
        cpri_hdr_pkg::word_t w;
        // Random filler in the unused bits
        w        = {$random(seed), $random(seed)};
        w[39:36] = ptype[3:0];
        w[35:28] = prb0[7:0];
        w[27:20] = prb1[7:0];
        w[18:12] = slot[6:0];
        w[11:8]  = symb[3:0];
        return w;
    endfunction

    // Wrong type, slot off the 5 grid, slot past 79; all with opening fields
    function automatic cpri_hdr_pkg::word_t drop_hdr(input int p);
        case (p % 3)
            0:       return make_hdr(3, 4, 0, 4, 0);
            1:       return make_hdr(8, 7, 0, 4, 0);
            default: return make_hdr(8, 84, 0, 4, 0);
        endcase
    endfunction

    task automatic send_packet(input cpri_hdr_pkg::word_t hdr, input int n_pay);
        logic [1:0]          cls;
        cpri_hdr_pkg::word_t pay;
        int                  i;
        cls = classify_hdr(hdr);
        @(posedge i_clk);
        i_rx_data <= hdr;
        i_rvalid  <= 1'b1;
        for (i = 0; i < n_pay; i++) begin
            pay = {$random(seed), $random(seed)};
            @(posedge i_clk);
            i_rx_data <= pay;
            model_payload(cls, i == 0, pay);
        end
        @(posedge i_clk);
        i_rvalid  <= 1'b0;
        i_rx_data <= '0;
        @(posedge i_clk);
    endtask

    // First packet opens the block, the rest never match the opening fields
    task automatic send_block(input logic with_drops);
        int p;
        for (p = 0; p < BLK_PKTS; p++) begin
            if (with_drops && p < DROP_PKTS) begin
                send_packet(drop_hdr(p), DROP_PAY);
            end
            send_packet(make_hdr(8, 5 * (p % 16) + 4, p * 4, p * 4 + 4, p % 14), PKT_PAY);
        end
    endtask

    task automatic drain_banks(input logic gaps);
        @(posedge i_clk);
        i_rd_en <= 1'b1;
        while (exp_q.size() != 0) begin
            @(posedge i_clk);
            if (gaps) begin
                i_rready <= ($random(seed) & 3) != 0;
            end
        end
        // Extra words would show up here
        repeat (16) @(posedge i_clk);
        i_rd_en  <= 1'b0;
        i_rready <= 1'b1;
    endtask

    task automatic wait_tready(input logic level);
        int n;
        n = 0;
        while (o_tready !== level && n < 50) begin
            @(negedge i_clk);
            n++;
        end
        if (o_tready !== level) begin
            stream_errs++;
            $display("o_tready did not reach %0d within 50 cycles at %0t", level, $time);
        end
    endtask

    //--------------------------------------------------
    // Compare tasks
    //--------------------------------------------------
    task automatic check_word(input string name, input cpri_hdr_pkg::word_t got,
                              input cpri_hdr_pkg::word_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_chip(input string name, input cpri_buf_pkg::chip_addr_t got,
                              input cpri_buf_pkg::chip_addr_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_agc(input string name, input cpri_buf_pkg::agc_t got,
                             input cpri_buf_pkg::agc_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Output monitor, sampled mid-cycle
    always @(negedge i_clk) begin
        if (!cpri_reset && o_tvalid) begin
            if (exp_q.size() == 0) begin
                stream_errs++;
                $display("Extra output word %h with nothing expected at %0t", o_tx_data, $time);
            end else begin
                exp_beat = exp_q.pop_front();
                check_word("o_tx_data", o_tx_data, exp_beat.data);
                check_chip("o_tx_addr", o_tx_addr, exp_beat.addr);
                check_flag("o_tx_last", o_tx_last, exp_beat.last);
                check_flag("o_symb_eop", o_symb_eop, exp_beat.eop);
                check_agc("o_fft_agc", o_fft_agc, exp_beat.agc);
                if (exp_beat.eop) begin
                    pending--;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("Run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
        $display("Errors: %0d value mismatches, %0d missing or extra words",
                 value_errs, stream_errs);
        $display("SOME TESTS FAILED");
        $finish;
    end

    //--------------------------------------------------
    // Test sequence
    //--------------------------------------------------
    initial begin
        seed        = 32'h5e02_f062;
        value_errs  = 0;
        stream_errs = 0;
        mdl_state   = 0;
        blk_cnt     = 0;
        pending     = 0;
        i_clk       = 1'b0;
        cpri_reset  = 1'b1;
        i_rx_data   = '0;
        i_rvalid    = 1'b0;
        i_enable    = 1'b1;
        i_rd_en     = 1'b0;
        i_rready    = 1'b1;
        repeat (4) @(posedge i_clk);
        cpri_reset <= 1'b0;

        // Idle state after reset
        @(negedge i_clk);
        check_flag("o_tvalid", o_tvalid, 1'b0);
        check_flag("o_tready", o_tready, 1'b1);

        // One clean block, then one with rejected packets mixed in
        send_block(1'b0);
        drain_banks(1'b0);
        send_block(1'b1);
        drain_banks(1'b0);

        // Both banks full, third block lost
        send_block(1'b0);
        send_block(1'b0);
        wait_tready(1'b0);
        send_block(1'b0);
        drain_banks(1'b0);
        wait_tready(1'b1);

        // Read back with ready gaps
        send_block(1'b0);
        send_block(1'b0);
        drain_banks(1'b1);

        // No block may open while disabled
        @(posedge i_clk);
        i_enable <= 1'b0;
        send_block(1'b0);
        drain_banks(1'b0);
        wait_tready(1'b1);

        if (exp_q.size() != 0) begin
            stream_errs++;
            $display("%0d expected words were never read out", exp_q.size());
        end
        $display("Errors: %0d value mismatches, %0d missing or extra words",
                 value_errs, stream_errs);
        if (value_errs == 0 && stream_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hdl/cpri_hdr_pkg.sv
hdl/cpri_buf_pkg.sv
hdl/cpri_hdr_filter.sv
hdl/cpri_blk_writer.sv
hdl/cpri_bank_ram.sv
hdl/cpri_chip_reader.sv
hdl/cpri_rx_top.sv
tb/cpri_rx_tb.sv

// File: Bender.yml
package:
  name: cpri_rx

sources:
  - hdl/cpri_hdr_pkg.sv
  - hdl/cpri_buf_pkg.sv
  - hdl/cpri_hdr_filter.sv
  - hdl/cpri_blk_writer.sv
  - hdl/cpri_bank_ram.sv
  - hdl/cpri_chip_reader.sv
  - hdl/cpri_rx_top.sv
  - target: simulation
    files:
      - tb/cpri_rx_tb.sv
